// ==== decode_front.f ====
common/rv_isa_pkg.sv
common/uop_pkg.sv
common/dec_if.sv
decode/decode_riscv.sv
decode/decode_stage.sv
src/decode_csr.sv
src/decode_front_top.sv
bench/tb_decode_front.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_decode_front
FILELIST ?= decode_front.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing -Wno-fatal

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "TESTS PASSED" $(LOG) || (echo "no pass result in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/tb_decode_front.sv ====
`timescale 1ns/10ps

module tb_decode_front
	import rv_isa_pkg::*;
	import uop_pkg::*;
();

	localparam int PREG_W = 6;
	localparam int CNT_W = 16;
	localparam int N_RAND = 48;
	localparam int N_PCREL = 16;
	localparam int NUM_INSNS = N_RAND + 8 * N_PCREL + 16;
	localparam int TIMEOUT_CYCLES = 40 * NUM_INSNS + 100;	// margin for reset and cfg access
	localparam logic [6:0] UNLISTED [4] = '{7'h0f, 7'h73, 7'h1b, 7'h3b};

	logic clk;
	logic rst_n;
	logic in_req;
	logic in_ack;
	logic [INSN_W-1:0] in_insn;
	logic [XLEN-1:0] in_pc;
	logic in_pred;
	logic [PHT_W-1:0] in_pht_idx;
	logic [XLEN-1:0] in_pred_target;
	logic out_req;
	logic out_ack;
	uop_op_e uop_op;
	logic [PREG_W-1:0] uop_src_a;
	logic [PREG_W-1:0] uop_src_b;
	logic [PREG_W-1:0] uop_dst;
	logic uop_src_a_valid;
	logic uop_src_b_valid;
	logic uop_dst_valid;
	logic uop_is_br;
	logic uop_br_pred;
	logic uop_is_mem;
	logic uop_is_store;
	logic uop_is_int;
	logic uop_is_cheap_int;
	logic [XLEN-1:0] uop_rvimm;
	logic [XLEN-1:0] uop_pc;
	logic [PHT_W-1:0] uop_pht_idx;
	logic [XLEN-1:0] uop_pred_target;
	logic cfg_we;
	csr_addr_e cfg_addr;
	logic [CNT_W-1:0] cfg_wdata;
	logic [CNT_W-1:0] cfg_rdata;

	logic [31:0] rng;
	logic tb_mode64;	// mode the bench last wrote
	int n_checks;
	int n_errors;
	int sent_total;
	int ii_total;
	int cycles = 0;

	decode_front_top #(
		.PREG_W(PREG_W),
		.CNT_W(CNT_W)
	) decode_front_top_inst (
		.clk(clk),
		.rst_n(rst_n),
		.in_req(in_req),
		.in_ack(in_ack),
		.in_insn(in_insn),
		.in_pc(in_pc),
		.in_pred(in_pred),
		.in_pht_idx(in_pht_idx),
		.in_pred_target(in_pred_target),
		.out_req(out_req),
		.out_ack(out_ack),
		.uop_op(uop_op),
		.uop_src_a(uop_src_a),
		.uop_src_b(uop_src_b),
		.uop_dst(uop_dst),
		.uop_src_a_valid(uop_src_a_valid),
		.uop_src_b_valid(uop_src_b_valid),
		.uop_dst_valid(uop_dst_valid),
		.uop_is_br(uop_is_br),
		.uop_br_pred(uop_br_pred),
		.uop_is_mem(uop_is_mem),
		.uop_is_store(uop_is_store),
		.uop_is_int(uop_is_int),
		.uop_is_cheap_int(uop_is_cheap_int),
		.uop_rvimm(uop_rvimm),
		.uop_pc(uop_pc),
		.uop_pht_idx(uop_pht_idx),
		.uop_pred_target(uop_pred_target),
		.cfg_we(cfg_we),
		.cfg_addr(cfg_addr),
		.cfg_wdata(cfg_wdata),
		.cfg_rdata(cfg_rdata)
	);

	always #20 clk = ~clk;

	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("timeout: the DUT stopped responding after %0d cycles", cycles);
			$display("TESTS FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] v;
		v = x ^ (x << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	// expected micro-op from the rv32i/rv64i decode rules
	function automatic uop_t ref_decode(input logic [31:0] insn, input logic [63:0] pc,
		input logic pred, input logic [7:0] pht, input logic [63:0] tgt, input logic m64);
		uop_t u;
		logic [2:0] f3;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [63:0] imm_i;
		logic [63:0] off;
		logic [63:0] rel;
		logic alu;
		f3 = insn[14:12];
		rd = insn[11:7];
		rs1 = insn[19:15];
		imm_i = {{52{insn[31]}}, insn[31:20]};
		if (insn[6:0] == OP_BRANCH)
			off = {{51{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
		else if (insn[6:0] == OP_JAL)
			off = {{43{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
		else
			off = {{32{insn[31]}}, insn[31:12], 12'h000};
		rel = pc + off;
		if (!m64)
			rel = {{32{rel[31]}}, rel[31:0]};	// rv32 wraps at 32 bits
		u = '0;
		u.op = II;
		u.pc = pc;
		u.pht_idx = pht;
		u.pred_target = tgt;
		alu = 1'b0;
		case (rv_opcode_e'(insn[6:0]))
			OP_LOAD:
			begin
				u.src_a_valid = 1'b1;
				u.dst_valid = (rd != 5'd0);
				u.is_mem = 1'b1;
				u.rvimm = imm_i;
				case (f3)
					3'd0: u.op = LB;
					3'd1: u.op = LH;
					3'd2: u.op = LW;
					3'd3: u.op = m64 ? LD : II;
					3'd4: u.op = LBU;
					3'd5: u.op = LHU;
					3'd6: u.op = m64 ? LWU : II;
					default: u.op = II;
				endcase
			end
			OP_STORE:
			begin
				u.src_a_valid = 1'b1;
				u.src_b_valid = 1'b1;
				u.is_mem = 1'b1;
				u.is_store = 1'b1;
				u.rvimm = {{52{insn[31]}}, insn[31:25], insn[11:7]};
				case (f3)
					3'd0: u.op = SB;
					3'd1: u.op = SH;
					3'd2: u.op = SW;
					3'd3: u.op = m64 ? SD : II;
					default: u.op = II;
				endcase
			end
			OP_IMM:
			begin
				alu = 1'b1;
				u.src_a_valid = 1'b1;
				u.dst_valid = 1'b1;
				u.rvimm = imm_i;
				case (f3)
					3'd0: u.op = ADDI;
					3'd1: u.op = (insn[31:26] == 6'h00) ? SLLI : II;
					3'd2: u.op = SLTI;
					3'd3: u.op = SLTIU;
					3'd4: u.op = XORI;
					3'd5: u.op = (insn[31:26] == 6'h00) ? SRLI : (insn[31:26] == 6'h10) ? SRAI : II;
					3'd6: u.op = ORI;
					default: u.op = ANDI;
				endcase
			end
			OP_REG:
			begin
				alu = 1'b1;
				u.src_a_valid = 1'b1;
				u.src_b_valid = 1'b1;
				u.dst_valid = 1'b1;
				if (insn[31:25] == 7'h00)
				begin
					case (f3)
						3'd0: u.op = ADDU;
						3'd1: u.op = SLL;
						3'd2: u.op = SLT;
						3'd3: u.op = SLTU;
						3'd4: u.op = XOR;
						3'd5: u.op = SRL;
						3'd6: u.op = OR;
						default: u.op = AND;
					endcase
				end
				else if (insn[31:25] == 7'h20 && f3 == 3'd0)
					u.op = SUBU;
				else if (insn[31:25] == 7'h20 && f3 == 3'd5)
					u.op = SRA;
			end
			OP_LUI, OP_AUIPC:
			begin
				alu = 1'b1;
				u.dst_valid = 1'b1;
				u.op = (insn[6:0] == OP_LUI) ? LUI : AUIPC;
				u.rvimm = (insn[6:0] == OP_LUI) ? off : rel;
			end
			OP_BRANCH:
			begin
				u.src_a_valid = 1'b1;
				u.src_b_valid = 1'b1;
				u.is_br = 1'b1;
				u.br_pred = pred;
				u.rvimm = rel;
				case (f3)
					3'd0: u.op = BEQ;
					3'd1: u.op = BNE;
					3'd4: u.op = BLT;
					3'd5: u.op = BGE;
					3'd6: u.op = BLTU;
					3'd7: u.op = BGEU;
					default: u.op = II;
				endcase
			end
			OP_JALR:
			begin
				u.src_a_valid = 1'b1;
				u.is_br = 1'b1;
				u.br_pred = 1'b1;
				u.rvimm = imm_i;
				if (f3 != 3'd0)
					u.op = II;
				else if (rd == 5'd0)
					u.op = (rs1 == LINK_REG_A || rs1 == LINK_REG_B) ? RET : JR;
				else
				begin
					u.op = JALR;
					u.dst_valid = 1'b1;
				end
			end
			OP_JAL:
			begin
				u.is_br = 1'b1;
				u.br_pred = 1'b1;
				u.rvimm = rel;
				u.op = (rd == 5'd0) ? J : JAL;
				u.dst_valid = (rd != 5'd0);
			end
			default: u.op = II;
		endcase
		if (alu && rd == 5'd0 && u.op != II)
			u.op = NOP;
		if (u.op == II || u.op == NOP)
		begin
			u.src_a_valid = 1'b0;
			u.src_b_valid = 1'b0;
			u.dst_valid = 1'b0;
			u.is_br = 1'b0;
			u.br_pred = 1'b0;
			u.is_mem = 1'b0;
			u.is_store = 1'b0;
		end
		else if (!u.is_mem)
		begin
			u.is_int = 1'b1;
			u.is_cheap_int = 1'b1;
		end
		// unused index fields read as zero
		u.src_a = u.src_a_valid ? {1'b0, rs1} : 6'd0;
		u.src_b = u.src_b_valid ? {1'b0, insn[24:20]} : 6'd0;
		u.dst = u.dst_valid ? {1'b0, rd} : 6'd0;
		return u;
	endfunction

	task automatic next_rand(output logic [31:0] v);
		rng = xorshift32(rng);
		v = rng;
	endtask

	task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] exp);
		n_checks++;
		if (got !== exp)
		begin
			n_errors++;
			$display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic compare_uop(input uop_t exp);
		check_value("uop_op", 64'(uop_op), 64'(exp.op));
		check_value("uop_src_a", 64'(uop_src_a), 64'(exp.src_a));
		check_value("uop_src_b", 64'(uop_src_b), 64'(exp.src_b));
		check_value("uop_dst", 64'(uop_dst), 64'(exp.dst));
		check_value("uop_src_a_valid", 64'(uop_src_a_valid), 64'(exp.src_a_valid));
		check_value("uop_src_b_valid", 64'(uop_src_b_valid), 64'(exp.src_b_valid));
		check_value("uop_dst_valid", 64'(uop_dst_valid), 64'(exp.dst_valid));
		check_value("uop_is_br", 64'(uop_is_br), 64'(exp.is_br));
		check_value("uop_br_pred", 64'(uop_br_pred), 64'(exp.br_pred));
		check_value("uop_is_mem", 64'(uop_is_mem), 64'(exp.is_mem));
		check_value("uop_is_store", 64'(uop_is_store), 64'(exp.is_store));
		check_value("uop_is_int", 64'(uop_is_int), 64'(exp.is_int));
		check_value("uop_is_cheap_int", 64'(uop_is_cheap_int), 64'(exp.is_cheap_int));
		check_value("uop_rvimm", uop_rvimm, exp.rvimm);
		check_value("uop_pc", uop_pc, exp.pc);
		check_value("uop_pht_idx", 64'(uop_pht_idx), 64'(exp.pht_idx));
		check_value("uop_pred_target", uop_pred_target, exp.pred_target);
	endtask

	task automatic write_cfg(input csr_addr_e addr, input logic [CNT_W-1:0] data);
		@(negedge clk);
		cfg_we = 1'b1;
		cfg_addr = addr;
		cfg_wdata = data;
		if (addr == CSR_MODE)
			tb_mode64 = data[0];
		@(negedge clk);
		cfg_we = 1'b0;
	endtask

	task automatic expect_cfg(input string what, input csr_addr_e addr, input int exp);
		@(negedge clk);
		cfg_addr = addr;
		#1;
		check_value(what, 64'(cfg_rdata), 64'(exp));
	endtask

	task automatic drive_insn(input logic [31:0] insn, input logic [63:0] pc, input logic pred,
		input logic [7:0] pht, input logic [63:0] tgt);
		@(negedge clk);
		in_insn = insn;
		in_pc = pc;
		in_pred = pred;
		in_pht_idx = pht;
		in_pred_target = tgt;
		in_req = 1'b1;
	endtask

	task automatic complete_in;
		while (!in_ack)
			@(negedge clk);
		in_req = 1'b0;
		while (in_ack)
			@(negedge clk);
	endtask

	task automatic wait_out_req;
		while (!out_req)
			@(negedge clk);
	endtask

	task automatic release_out;
		out_ack = 1'b1;
		while (out_req)
			@(negedge clk);
		out_ack = 1'b0;
	endtask

	task automatic run_insn(input logic [31:0] insn);
		logic [31:0] lo;
		logic [31:0] hi;
		logic [31:0] extra;
		logic [63:0] pc;
		logic [63:0] tgt;
		uop_t exp;
		next_rand(lo);
		next_rand(hi);
		next_rand(extra);
		pc = {hi, lo[31:2], 2'b00};
		tgt = {hi ^ extra, lo ^ extra};
		exp = ref_decode(insn, pc, extra[0], extra[15:8], tgt, tb_mode64);
		drive_insn(insn, pc, extra[0], extra[15:8], tgt);
		complete_in();
		wait_out_req();
		compare_uop(exp);
		release_out();
		sent_total++;
		if (exp.op == II)
			ii_total++;
	endtask

	task automatic check_counters;
		repeat (2) @(negedge clk);
		expect_cfg("decoded counter", CSR_DECODED, sent_total);
		expect_cfg("illegal counter", CSR_ILLEGAL, ii_total);
	endtask

	task automatic test_reset;
		check_value("in_ack after reset", 64'(in_ack), 64'd0);
		check_value("out_req after reset", 64'(out_req), 64'd0);
		expect_cfg("mode64 after reset", CSR_MODE, 1);
		expect_cfg("decoded after reset", CSR_DECODED, 0);
		expect_cfg("illegal after reset", CSR_ILLEGAL, 0);
	endtask

	task automatic test_alu_mem;
		logic [31:0] r;
		logic [31:0] insn;
		rv_opcode_e opc;
		for (int i = 0; i < N_RAND; i++)
		begin
			next_rand(r);
			case (i % 4)
				0: opc = OP_IMM;
				1: opc = OP_REG;
				2: opc = OP_LOAD;
				default: opc = OP_STORE;
			endcase
			insn = {r[31:7], opc};
			if (opc == OP_REG)
				insn[31:25] = r[0] ? 7'h20 : 7'h00;
			if (opc == OP_IMM && insn[13:12] == 2'b01)
				insn[31:26] = r[0] ? 6'h10 : 6'h00;	// mostly legal shifts
			if (i % 8 < 2)
				insn[11:7] = 5'd0;
			run_insn(insn);
		end
	endtask

	task automatic test_pc_rel;
		logic [31:0] r;
		logic [31:0] insn;
		logic [4:0] rs1;
		for (int m = 1; m >= 0; m--)
		begin
			write_cfg(CSR_MODE, 16'(m));
			for (int i = 0; i < N_PCREL; i++)
			begin
				next_rand(r);
				run_insn({r[31:7], OP_BRANCH});
				run_insn({r[31:7], OP_AUIPC});
				insn = {r[31:7], OP_JAL};
				if (r[0])
					insn[11:7] = 5'd0;
				run_insn(insn);
				case (r[3:2])
					2'd0: rs1 = LINK_REG_A;
					2'd1: rs1 = LINK_REG_B;
					default: rs1 = r[19:15];
				endcase
				insn = {r[31:20], rs1, 3'd0, r[11:7], OP_JALR};
				if (r[1])
					insn[11:7] = 5'd0;	// ret or jr
				run_insn(insn);
			end
		end
	endtask

	task automatic test_illegal;
		logic [31:0] r;
		write_cfg(CSR_MODE, 16'd0);
		next_rand(r);
		run_insn({r[31:15], 3'd3, r[11:7], OP_LOAD});
		run_insn({r[31:15], 3'd6, r[11:7], OP_LOAD});
		run_insn({r[31:15], 3'd3, r[11:7], OP_STORE});
		for (int m = 0; m < 2; m++)
		begin
			for (int k = 0; k < 4; k++)
			begin
				next_rand(r);
				run_insn({r[31:7], UNLISTED[k]});
			end
			write_cfg(CSR_MODE, 16'd1);
		end
		check_counters();
	endtask

	task automatic test_backpressure;
		logic [31:0] insn_a;
		logic [31:0] insn_b;
		uop_t exp_a;
		uop_t exp_b;
		insn_a = {12'h7f3, 5'd4, 3'd0, 5'd3, OP_IMM};
		insn_b = {7'h41, 5'd9, 5'd2, 3'd2, 5'd8, OP_STORE};
		exp_a = ref_decode(insn_a, 64'h8000_1000, 1'b0, 8'h21, 64'h0, tb_mode64);
		exp_b = ref_decode(insn_b, 64'h8000_1004, 1'b1, 8'h22, 64'h40, tb_mode64);
		drive_insn(insn_a, 64'h8000_1000, 1'b0, 8'h21, 64'h0);
		complete_in();
		wait_out_req();
		compare_uop(exp_a);
		drive_insn(insn_b, 64'h8000_1004, 1'b1, 8'h22, 64'h40);
		repeat (10)
		begin
			@(negedge clk);
			check_value("in_ack while stalled", 64'(in_ack), 64'd0);
			check_value("out_req while stalled", 64'(out_req), 64'd1);
			compare_uop(exp_a);
		end
		release_out();
		complete_in();
		wait_out_req();
		compare_uop(exp_b);
		release_out();
		sent_total += 2;
	endtask

	task automatic test_counter_clear;
		write_cfg(CSR_DECODED, 16'h5a5a);
		write_cfg(CSR_ILLEGAL, 16'h0001);
		expect_cfg("decoded after clear", CSR_DECODED, 0);
		expect_cfg("illegal after clear", CSR_ILLEGAL, 0);
		sent_total = 0;
		ii_total = 0;
		run_insn({12'h001, 5'd1, 3'd0, 5'd2, OP_IMM});
		run_insn(32'h0000_0073);	// ecall
		run_insn({20'h12345, 5'd7, OP_LUI});
		check_counters();
	endtask

	initial
	begin
		clk = 1'b0;
		rst_n = 1'b0;
		in_req = 1'b0;
		in_insn = '0;
		in_pc = '0;
		in_pred = 1'b0;
		in_pht_idx = '0;
		in_pred_target = '0;
		out_ack = 1'b0;
		cfg_we = 1'b0;
		cfg_addr = CSR_MODE;
		cfg_wdata = '0;
		rng = 32'hf40b6746;
		tb_mode64 = 1'b1;
		n_checks = 0;
		n_errors = 0;
		sent_total = 0;
		ii_total = 0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		test_reset();
		test_alu_mem();
		test_pc_rel();
		test_illegal();
		test_backpressure();
		test_counter_clear();
		$display("checks %0d, errors %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// ==== src/decode_front_top.sv ====
`timescale 1ns/10ps

module decode_front_top
	import rv_isa_pkg::*;
	import uop_pkg::*;
#(
	parameter int PREG_W = 6,
	parameter int CNT_W = 16
)
(
	input logic clk,
	input logic rst_n,
	input logic in_req,
	output logic in_ack,
	input logic [INSN_W-1:0] in_insn,
	input logic [XLEN-1:0] in_pc,
	input logic in_pred,
	input logic [PHT_W-1:0] in_pht_idx,
	input logic [XLEN-1:0] in_pred_target,
	output logic out_req,
	input logic out_ack,
	output uop_op_e uop_op,
	output logic [PREG_W-1:0] uop_src_a,
	output logic [PREG_W-1:0] uop_src_b,
	output logic [PREG_W-1:0] uop_dst,
	output logic uop_src_a_valid,
	output logic uop_src_b_valid,
	output logic uop_dst_valid,
	output logic uop_is_br,
	output logic uop_br_pred,
	output logic uop_is_mem,
	output logic uop_is_store,
	output logic uop_is_int,
	output logic uop_is_cheap_int,
	output logic [XLEN-1:0] uop_rvimm,
	output logic [XLEN-1:0] uop_pc,
	output logic [PHT_W-1:0] uop_pht_idx,
	output logic [XLEN-1:0] uop_pred_target,
	input logic cfg_we,
	input csr_addr_e cfg_addr,
	input logic [CNT_W-1:0] cfg_wdata,
	output logic [CNT_W-1:0] cfg_rdata
);

	uop_t uop;
	logic mode64;
	logic count_en;
	logic illegal;

	dec_if #(
		.PREG_W(PREG_W)
	) in_if ();

	assign in_if.req = in_req;
	assign in_if.insn = in_insn;
	assign in_if.pc = in_pc;
	assign in_if.pred = in_pred;
	assign in_if.pht_idx = in_pht_idx;
	assign in_if.pred_target = in_pred_target;
	assign in_ack = in_if.ack;

	decode_stage #(
		.PREG_W(PREG_W)
	) decode_stage_inst (
		.clk(clk),
		.rst_n(rst_n),
		.mode64(mode64),
		.in_port(in_if.consumer),
		.out_req(out_req),
		.out_ack(out_ack),
		.uop(uop),
		.count_en(count_en),
		.illegal(illegal)
	);

	decode_csr #(
		.CNT_W(CNT_W)
	) decode_csr_inst (
		.clk(clk),
		.rst_n(rst_n),
		.cfg_we(cfg_we),
		.cfg_addr(cfg_addr),
		.cfg_wdata(cfg_wdata),
		.cfg_rdata(cfg_rdata),
		.count_en(count_en),
		.illegal(illegal),
		.mode64(mode64)
	);

	assign uop_op = uop.op;
	assign uop_src_a = PREG_W'(uop.src_a);	// upper bits zero
	assign uop_src_b = PREG_W'(uop.src_b);
	assign uop_dst = PREG_W'(uop.dst);
	assign uop_src_a_valid = uop.src_a_valid;
	assign uop_src_b_valid = uop.src_b_valid;
	assign uop_dst_valid = uop.dst_valid;
	assign uop_is_br = uop.is_br;
	assign uop_br_pred = uop.br_pred;
	assign uop_is_mem = uop.is_mem;
	assign uop_is_store = uop.is_store;
	assign uop_is_int = uop.is_int;
	assign uop_is_cheap_int = uop.is_cheap_int;
	assign uop_rvimm = uop.rvimm;
	assign uop_pc = uop.pc;
	assign uop_pht_idx = uop.pht_idx;
	assign uop_pred_target = uop.pred_target;

endmodule

// ==== src/decode_csr.sv ====
`timescale 1ns/10ps

module decode_csr
	import uop_pkg::*;
#(
	parameter int CNT_W = 16
)
(
	input logic clk,
	input logic rst_n,
	input logic cfg_we,
	input csr_addr_e cfg_addr,
	input logic [CNT_W-1:0] cfg_wdata,
	output logic [CNT_W-1:0] cfg_rdata,
	input logic count_en,
	input logic illegal,
	output logic mode64
);

	logic [CNT_W-1:0] decoded_cnt;
	logic [CNT_W-1:0] illegal_cnt;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			mode64 <= 1'b1;
			decoded_cnt <= '0;
			illegal_cnt <= '0;
		end
		else
		begin
			if (cfg_we && cfg_addr == CSR_MODE)
				mode64 <= cfg_wdata[0];
			if (cfg_we && cfg_addr == CSR_DECODED)
				decoded_cnt <= '0;	// any write clears
			else if (count_en && decoded_cnt != '1)
				decoded_cnt <= decoded_cnt + 1'b1;
			if (cfg_we && cfg_addr == CSR_ILLEGAL)
				illegal_cnt <= '0;
			else if (illegal && illegal_cnt != '1)
				illegal_cnt <= illegal_cnt + 1'b1;	// saturates
		end
	end

	always_comb
	begin
		case (cfg_addr)
			CSR_MODE: cfg_rdata = CNT_W'(mode64);
			CSR_DECODED: cfg_rdata = decoded_cnt;
			CSR_ILLEGAL: cfg_rdata = illegal_cnt;
			default: cfg_rdata = '0;
		endcase
	end

endmodule

// ==== decode/decode_stage.sv ====
`timescale 1ns/10ps

module decode_stage
	import uop_pkg::*;
#(
	parameter int PREG_W = 6
)
(
	input logic clk,
	input logic rst_n,
	input logic mode64,
	dec_if.consumer in_port,
	output logic out_req,
	input logic out_ack,
	output uop_t uop,
	output logic count_en,
	output logic illegal
);

	typedef enum logic [1:0] {
		IDLE,
		FULL,
		WAIT_OUT_LOW,
		WAIT_IN_LOW
	} state_e;

	state_e state;
	uop_t dec_uop;
	logic in_ack;
	logic capture;

	decode_riscv #(
		.PREG_W(PREG_W)
	) decode_riscv_inst (
		.mode64(mode64),
		.insn(in_port.insn),
		.pc(in_port.pc),
		.pred(in_port.pred),
		.pht_idx(in_port.pht_idx),
		.pred_target(in_port.pred_target),
		.uop(dec_uop)
	);

	assign capture = (state == IDLE) && in_port.req;
	assign in_port.ack = in_ack;

	always_ff @(posedge clk)
	begin
		if (capture)
			uop <= dec_uop;	// held until the next capture
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= IDLE;
			in_ack <= 1'b0;
			out_req <= 1'b0;
			count_en <= 1'b0;
			illegal <= 1'b0;
		end
		else
		begin
			count_en <= 1'b0;
			illegal <= 1'b0;
			if (in_ack && !in_port.req)
				in_ack <= 1'b0;	// input side closes on its own
			case (state)
				IDLE:
				begin
					if (capture)
					begin
						in_ack <= 1'b1;
						out_req <= 1'b1;
						count_en <= 1'b1;
						illegal <= (dec_uop.op == II);
						state <= FULL;
					end
				end
				FULL:
				begin
					if (out_ack)
					begin
						out_req <= 1'b0;
						state <= WAIT_OUT_LOW;
					end
				end
				WAIT_OUT_LOW:
				begin
					if (!out_ack)
						state <= WAIT_IN_LOW;
				end
				WAIT_IN_LOW:
				begin
					if (!in_ack)
						state <= IDLE;
				end
			endcase
		end
	end

endmodule

// ==== decode/decode_riscv.sv ====
`timescale 1ns/10ps

module decode_riscv
	import rv_isa_pkg::*;
	import uop_pkg::*;
#(
	parameter int PREG_W = 6
)
(
	input logic mode64,
	input logic [INSN_W-1:0] insn,
	input logic [XLEN-1:0] pc,
	input logic pred,
	input logic [PHT_W-1:0] pht_idx,
	input logic [XLEN-1:0] pred_target,
	output uop_t uop
);

	rv_opcode_e opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [5:0] funct6;
	logic [PREG_W-1:0] rd;
	logic [PREG_W-1:0] rs1;
	logic [PREG_W-1:0] rs2;
	logic rd_zero;
	logic rs1_is_link;
	logic alu_wr;
	logic [XLEN-1:0] imm_i;
	logic [XLEN-1:0] imm_s;
	logic [XLEN-1:0] imm_u;
	logic [XLEN-1:0] imm_b;
	logic [XLEN-1:0] imm_j;
	logic [XLEN-1:0] pc_imm;
	logic [XLEN-1:0] pc_sum;
	logic [XLEN-1:0] pc_rel;

	assign opcode = rv_opcode_e'(insn[6:0]);
	assign funct3 = insn[14:12];
	assign funct7 = insn[31:25];
	assign funct6 = insn[31:26];
	assign rd = PREG_W'(insn[11:7]);
	assign rs1 = PREG_W'(insn[19:15]);
	assign rs2 = PREG_W'(insn[24:20]);
	assign rd_zero = (insn[11:7] == '0);
	assign rs1_is_link = (insn[19:15] == LINK_REG_A) || (insn[19:15] == LINK_REG_B);

	assign imm_i = {{(XLEN-12){insn[31]}}, insn[31:20]};
	assign imm_s = {{(XLEN-12){insn[31]}}, insn[31:25], insn[11:7]};
	assign imm_u = {{(XLEN-32){insn[31]}}, insn[31:12], 12'd0};
	assign imm_b = {{(XLEN-13){insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
	assign imm_j = {{(XLEN-21){insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};

	// pc-relative target for branch, jal and auipc
	assign pc_imm = (opcode == OP_BRANCH) ? imm_b : (opcode == OP_JAL) ? imm_j : imm_u;
	assign pc_sum = pc + pc_imm;
	assign pc_rel = mode64 ? pc_sum : {{(XLEN-32){pc_sum[31]}}, pc_sum[31:0]};

	always_comb
	begin
		uop = '0;
		uop.op = II;
		uop.pc = pc;
		uop.pht_idx = pht_idx;
		uop.pred_target = pred_target;
		alu_wr = 1'b0;
		case (opcode)
			OP_LOAD:
			begin
				uop.dst = UOP_REG_W'(rd);
				uop.src_a = UOP_REG_W'(rs1);
				uop.dst_valid = !rd_zero;
				uop.src_a_valid = 1'b1;
				uop.is_mem = 1'b1;
				uop.rvimm = imm_i;
				case (funct3)
					F3_SZ_B: uop.op = LB;
					F3_SZ_H: uop.op = LH;
					F3_SZ_W: uop.op = LW;
					F3_SZ_D: uop.op = mode64 ? LD : II;
					F3_SZ_BU: uop.op = LBU;
					F3_SZ_HU: uop.op = LHU;
					F3_SZ_WU: uop.op = mode64 ? LWU : II;
					default: uop.op = II;
				endcase
			end
			OP_STORE:
			begin
				uop.src_a = UOP_REG_W'(rs1);
				uop.src_b = UOP_REG_W'(rs2);
				uop.src_a_valid = 1'b1;
				uop.src_b_valid = 1'b1;
				uop.is_mem = 1'b1;
				uop.is_store = 1'b1;
				uop.rvimm = imm_s;
				case (funct3)
					F3_SZ_B: uop.op = SB;
					F3_SZ_H: uop.op = SH;
					F3_SZ_W: uop.op = SW;
					F3_SZ_D: uop.op = mode64 ? SD : II;
					default: uop.op = II;
				endcase
			end
			OP_IMM:
			begin
				alu_wr = 1'b1;
				uop.dst = UOP_REG_W'(rd);
				uop.src_a = UOP_REG_W'(rs1);
				uop.dst_valid = 1'b1;
				uop.src_a_valid = 1'b1;
				uop.is_int = 1'b1;
				uop.is_cheap_int = 1'b1;
				uop.rvimm = imm_i;
				case (funct3)
					F3_ADD: uop.op = ADDI;
					F3_SLL: uop.op = (funct6 == F6_BASE) ? SLLI : II;
					F3_SLT: uop.op = SLTI;
					F3_SLTU: uop.op = SLTIU;
					F3_XOR: uop.op = XORI;
					F3_SR:
					begin
						if (funct6 == F6_BASE)
							uop.op = SRLI;
						else if (funct6 == F6_SRA)
							uop.op = SRAI;
					end
					F3_OR: uop.op = ORI;
					F3_AND: uop.op = ANDI;
				endcase
			end
			OP_REG:
			begin
				alu_wr = 1'b1;
				uop.dst = UOP_REG_W'(rd);
				uop.src_a = UOP_REG_W'(rs1);
				uop.src_b = UOP_REG_W'(rs2);
				uop.dst_valid = 1'b1;
				uop.src_a_valid = 1'b1;
				uop.src_b_valid = 1'b1;
				uop.is_int = 1'b1;
				uop.is_cheap_int = 1'b1;
				if (funct7 == F7_BASE)
				begin
					case (funct3)
						F3_ADD: uop.op = ADDU;
						F3_SLL: uop.op = SLL;
						F3_SLT: uop.op = SLT;
						F3_SLTU: uop.op = SLTU;
						F3_XOR: uop.op = XOR;
						F3_SR: uop.op = SRL;
						F3_OR: uop.op = OR;
						F3_AND: uop.op = AND;
					endcase
				end
				else if (funct7 == F7_ALT && funct3 == F3_ADD)
					uop.op = SUBU;
				else if (funct7 == F7_ALT && funct3 == F3_SR)
					uop.op = SRA;
			end
			OP_LUI:
			begin
				alu_wr = 1'b1;
				uop.op = LUI;
				uop.dst = UOP_REG_W'(rd);
				uop.dst_valid = 1'b1;
				uop.is_int = 1'b1;
				uop.is_cheap_int = 1'b1;
				uop.rvimm = imm_u;
			end
			OP_AUIPC:
			begin
				alu_wr = 1'b1;
				uop.op = AUIPC;
				uop.dst = UOP_REG_W'(rd);
				uop.dst_valid = 1'b1;
				uop.is_int = 1'b1;
				uop.is_cheap_int = 1'b1;
				uop.rvimm = pc_rel;
			end
			OP_BRANCH:
			begin
				uop.src_a = UOP_REG_W'(rs1);
				uop.src_b = UOP_REG_W'(rs2);
				uop.src_a_valid = 1'b1;
				uop.src_b_valid = 1'b1;
				uop.is_br = 1'b1;
				uop.br_pred = pred;
				uop.is_int = 1'b1;
				uop.is_cheap_int = 1'b1;
				uop.rvimm = pc_rel;
				case (funct3)
					F3_BEQ: uop.op = BEQ;
					F3_BNE: uop.op = BNE;
					F3_BLT: uop.op = BLT;
					F3_BGE: uop.op = BGE;
					F3_BLTU: uop.op = BLTU;
					F3_BGEU: uop.op = BGEU;
					default: uop.op = II;
				endcase
			end
			OP_JALR:
			begin
				uop.src_a = UOP_REG_W'(rs1);
				uop.src_a_valid = 1'b1;
				uop.is_br = 1'b1;
				uop.br_pred = 1'b1;
				uop.is_int = 1'b1;
				uop.is_cheap_int = 1'b1;
				uop.rvimm = imm_i;
				if (funct3 == F3_JALR && rd_zero)
					uop.op = rs1_is_link ? RET : JR;	// link rule
				else if (funct3 == F3_JALR)
				begin
					uop.op = JALR;
					uop.dst = UOP_REG_W'(rd);
					uop.dst_valid = 1'b1;
				end
			end
			OP_JAL:
			begin
				uop.is_br = 1'b1;
				uop.br_pred = 1'b1;
				uop.is_int = 1'b1;
				uop.is_cheap_int = 1'b1;
				uop.rvimm = pc_rel;
				if (rd_zero)
					uop.op = J;
				else
				begin
					uop.op = JAL;
					uop.dst = UOP_REG_W'(rd);
					uop.dst_valid = 1'b1;
				end
			end
			default: uop.op = II;	// fence, system, rv64 w-forms
		endcase

		if (alu_wr && rd_zero && uop.op != II)
			uop.op = NOP;
		// nop and illegal carry no operands
		if (uop.op == II || uop.op == NOP)
		begin
			uop.src_a = '0;
			uop.src_b = '0;
			uop.dst = '0;
			uop.src_a_valid = 1'b0;
			uop.src_b_valid = 1'b0;
			uop.dst_valid = 1'b0;
			uop.is_br = 1'b0;
			uop.br_pred = 1'b0;
			uop.is_mem = 1'b0;
			uop.is_store = 1'b0;
			uop.is_int = 1'b0;
			uop.is_cheap_int = 1'b0;
		end
	end

endmodule

// ==== common/dec_if.sv ====
`timescale 1ns/10ps

interface dec_if
	import rv_isa_pkg::*;
	import uop_pkg::*;
#(
	parameter int PREG_W = 6
);

	logic req;
	logic ack;
	logic [INSN_W-1:0] insn;
	logic [XLEN-1:0] pc;
	logic pred;	// taken prediction from fetch
	logic [PHT_W-1:0] pht_idx;
	logic [XLEN-1:0] pred_target;

	modport producer (
		output req, insn, pc, pred, pht_idx, pred_target,
		input ack
	);

	modport consumer (
		input req, insn, pc, pred, pht_idx, pred_target,
		output ack
	);

endinterface

// ==== common/uop_pkg.sv ====
package uop_pkg;

	import rv_isa_pkg::*;

	localparam int UOP_REG_W = 6;
	localparam int PHT_W = 8;

	typedef enum logic [5:0] {
		II,
		NOP,
		LB, LH, LW, LD, LBU, LHU, LWU,
		SB, SH, SW, SD,
		ADDI, SLLI, SLTI, SLTIU, XORI, SRLI, SRAI, ORI, ANDI,
		ADDU, SUBU, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
		LUI,
		AUIPC,
		BEQ, BNE, BLT, BGE, BLTU, BGEU,
		J, JAL, JR, JALR, RET
	} uop_op_e;

	// register indices are zero-filled into the low bits
	typedef struct packed {
		uop_op_e op;
		logic [UOP_REG_W-1:0] src_a;
		logic [UOP_REG_W-1:0] src_b;
		logic [UOP_REG_W-1:0] dst;
		logic src_a_valid;
		logic src_b_valid;
		logic dst_valid;
		logic is_br;
		logic br_pred;
		logic is_mem;
		logic is_store;
		logic is_int;
		logic is_cheap_int;
		logic [XLEN-1:0] rvimm;
		logic [XLEN-1:0] pc;
		logic [PHT_W-1:0] pht_idx;
		logic [XLEN-1:0] pred_target;
	} uop_t;

	typedef enum logic [1:0] {
		CSR_MODE = 2'd0,
		CSR_DECODED = 2'd1,
		CSR_ILLEGAL = 2'd2
	} csr_addr_e;

endpackage

// ==== common/rv_isa_pkg.sv ====
package rv_isa_pkg;

	localparam int INSN_W = 32;
	localparam int XLEN = 64;
	localparam int RV_REG_W = 5;	// architectural register index

	typedef enum logic [6:0] {
		OP_LOAD = 7'h03,
		OP_IMM = 7'h13,
		OP_AUIPC = 7'h17,
		OP_STORE = 7'h23,
		OP_REG = 7'h33,
		OP_LUI = 7'h37,
		OP_BRANCH = 7'h63,
		OP_JALR = 7'h67,
		OP_JAL = 7'h6f
	} rv_opcode_e;

	// x1 and x5 are the link registers
	localparam logic [RV_REG_W-1:0] LINK_REG_A = 5'd1;
	localparam logic [RV_REG_W-1:0] LINK_REG_B = 5'd5;

	localparam logic [2:0] F3_ADD = 3'd0;	// alu group
	localparam logic [2:0] F3_SLL = 3'd1;
	localparam logic [2:0] F3_SLT = 3'd2;
	localparam logic [2:0] F3_SLTU = 3'd3;
	localparam logic [2:0] F3_XOR = 3'd4;
	localparam logic [2:0] F3_SR = 3'd5;
	localparam logic [2:0] F3_OR = 3'd6;
	localparam logic [2:0] F3_AND = 3'd7;

	localparam logic [2:0] F3_SZ_B = 3'd0;	// load/store size
	localparam logic [2:0] F3_SZ_H = 3'd1;
	localparam logic [2:0] F3_SZ_W = 3'd2;
	localparam logic [2:0] F3_SZ_D = 3'd3;
	localparam logic [2:0] F3_SZ_BU = 3'd4;
	localparam logic [2:0] F3_SZ_HU = 3'd5;
	localparam logic [2:0] F3_SZ_WU = 3'd6;

	localparam logic [2:0] F3_BEQ = 3'd0;	// branch conditions
	localparam logic [2:0] F3_BNE = 3'd1;
	localparam logic [2:0] F3_BLT = 3'd4;
	localparam logic [2:0] F3_BGE = 3'd5;
	localparam logic [2:0] F3_BLTU = 3'd6;
	localparam logic [2:0] F3_BGEU = 3'd7;
	localparam logic [2:0] F3_JALR = 3'd0;

	localparam logic [6:0] F7_BASE = 7'h00;
	localparam logic [6:0] F7_ALT = 7'h20;	// sub, sra
	localparam logic [5:0] F6_BASE = 6'h00;	// rv64 immediate shifts
	localparam logic [5:0] F6_SRA = 6'h10;

endpackage
